/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f fpu_lite.f --top-module tb_fpu_top -o sim_fpu

run: build
	./obj_dir/sim_fpu | tee sim.log
	grep -q "test passed" sim.log

lint:
	verilator --lint-only -Wall --top-module fpu_top \
		verilog/fp_format_pkg.sv verilog/fpu_op_pkg.sv \
		verilog/fp_unpack.sv verilog/fp_mul_path.sv verilog/fp_simple_ops.sv \
		verilog/fpu_ctrl.sv verilog/fpu_top.sv

clean:
	rm -rf obj_dir sim.log

/* fpu_lite.f */
+incdir+include
verilog/fp_format_pkg.sv
verilog/fpu_op_pkg.sv
verilog/fp_unpack.sv
verilog/fp_mul_path.sv
verilog/fp_simple_ops.sv
verilog/fpu_ctrl.sv
verilog/fpu_top.sv
testbench/tb_fpu_top.sv

/* include/fpu_ref.svh */
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// Exponent arrives as a double-width field
// Single values come back NaN-boxed
function automatic logic [63:0] pack_fields(input bit sgl, input bit s, input int e,
                                            input logic [51:0] f);
    if (sgl)
        return {32'hffff_ffff, s, e[7:0], f[51:29]};
    return {s, e[10:0], f};
endfunction

function automatic logic [63:0] nan_box(input logic [63:0] w, input bit sgl);
    return sgl ? {32'hffff_ffff, w[31:0]} : w;
endfunction

// Operand fields in double bias
// Denormals read as zero
function automatic void split_fields(input logic [63:0] w, input bit sgl, output bit s,
                                     output int e, output logic [52:0] m, output bit z,
                                     output bit inf, output bit nan, output bit snan);
    bit emax;
    logic [51:0] f;
    s = sgl ? w[31] : w[63];
    e = sgl ? int'(w[30:23]) + 896 : int'(w[62:52]);
    f = sgl ? {w[22:0], 29'b0} : w[51:0];
    emax = sgl ? (w[30:23] == 8'hff) : (w[62:52] == 11'h7ff);
    z = sgl ? (w[30:23] == 0) : (w[62:52] == 0);
    inf = emax && f == 0;
    nan = emax && f != 0;
    snan = nan && !f[51];
    m = z ? '0 : {1'b1, f};
    if (z)
        e = 0;
endfunction

// Signed position on the number line where either zero maps to 0
function automatic logic signed [67:0] order_key(input bit s, input bit z, input int e,
                                                 input logic [52:0] m);
    logic signed [67:0] mag;
    mag = $signed({3'b0, e[11:0], m});
    if (z)
        return '0;
    return s ? -mag : mag;
endfunction

function automatic logic [63:0] mul_expected(input logic [63:0] x, y, input bit sgl,
                                             output logic [4:0] fl);
    bit sa, sb, za, zb, ia, ib, na, nb, qa, qb, s, lost;
    int ea, eb, e;
    logic [52:0] ma, mb;
    logic [105:0] p;
    logic [51:0] f;
    split_fields(x, sgl, sa, ea, ma, za, ia, na, qa);
    split_fields(y, sgl, sb, eb, mb, zb, ib, nb, qb);
    fl = '0;
    s = sa ^ sb;
    if (na || nb || (ia && zb) || (za && ib)) begin
        fl[fpu_op_pkg::flag_nv] = (na || nb) ? (qa || qb) : 1'b1;
        return pack_fields(sgl, 1'b0, 2047, {1'b1, 51'b0});
    end
    if (ia || ib)
        return pack_fields(sgl, s, 2047, '0);
    if (za || zb)
        return pack_fields(sgl, s, 0, '0);
    p = ma * mb;
    e = ea + eb - 1023 + int'(p[105]);
    f = p[105] ? p[104:53] : p[103:52];
    lost = p[105] ? |p[52:0] : |p[51:0];
    if (sgl) begin
        e = e - 896;
        lost = lost || (|f[28:0]);
    end
    if (e >= (sgl ? 255 : 2047)) begin
        fl[fpu_op_pkg::flag_of] = 1'b1;
        fl[fpu_op_pkg::flag_nx] = 1'b1;
        return pack_fields(sgl, s, 2047, '0);
    end
    if (e <= 0) begin
        fl[fpu_op_pkg::flag_uf] = 1'b1;
        fl[fpu_op_pkg::flag_nx] = 1'b1;
        return pack_fields(sgl, s, 0, '0);
    end
    fl[fpu_op_pkg::flag_nx] = lost;
    return pack_fields(sgl, s, e, f);
endfunction

function automatic logic [63:0] simple_expected(input fpu_op_pkg::fpu_op_t op,
                                                input logic [63:0] x, y, input bit sgl,
                                                output logic [63:0] ir,
                                                output logic [4:0] fl);
    bit sa, sb, za, zb, ia, ib, na, nb, qa, qb, eq, lt, inj, m0;
    int ea, eb, idx;
    logic [52:0] ma, mb;
    logic signed [67:0] ka, kb;
    split_fields(x, sgl, sa, ea, ma, za, ia, na, qa);
    split_fields(y, sgl, sb, eb, mb, zb, ib, nb, qb);
    ir = '0;
    fl = '0;
    ka = order_key(sa, za, ea, ma);
    kb = order_key(sb, zb, eb, mb);
    eq = (ka == kb);
    lt = (ka < kb);
    m0 = sgl ? (x[22:0] == 0) : (x[51:0] == 0);
    case (op)
        fpu_op_pkg::FPU_SGNJ, fpu_op_pkg::FPU_SGNJN, fpu_op_pkg::FPU_SGNJX: begin
            inj = (op == fpu_op_pkg::FPU_SGNJ) ? sb
                : (op == fpu_op_pkg::FPU_SGNJN) ? !sb : sa ^ sb;
            return sgl ? {32'hffff_ffff, inj, x[30:0]} : {inj, x[62:0]};
        end
        fpu_op_pkg::FPU_CLASS: begin
            if (na)
                idx = qa ? 8 : 9;
            else if (ia)
                idx = sa ? 0 : 7;
            else if (za)
                idx = m0 ? (sa ? 3 : 4) : (sa ? 2 : 5);
            else
                idx = sa ? 1 : 6;
            ir = 64'd1 << idx;
        end
        fpu_op_pkg::FPU_CMP_EQ: begin
            ir = 64'(eq && !(na || nb));
            fl[fpu_op_pkg::flag_nv] = qa || qb;
        end
        fpu_op_pkg::FPU_CMP_LT, fpu_op_pkg::FPU_CMP_LE: begin
            ir = 64'((lt || (op == fpu_op_pkg::FPU_CMP_LE && eq)) && !(na || nb));
            fl[fpu_op_pkg::flag_nv] = na || nb;
        end
        fpu_op_pkg::FPU_MIN, fpu_op_pkg::FPU_MAX: begin
            fl[fpu_op_pkg::flag_nv] = qa || qb;
            if (na && nb)
                return pack_fields(sgl, 1'b0, 2047, {1'b1, 51'b0});
            if (na)
                return nan_box(y, sgl);
            if (nb)
                return nan_box(x, sgl);
            if (op == fpu_op_pkg::FPU_MIN)
                return lt ? nan_box(x, sgl) : nan_box(y, sgl);
            return lt ? nan_box(y, sgl) : nan_box(x, sgl);
        end
        default: ;
    endcase
    return '0;
endfunction

`endif

/* testbench/tb_fpu_top.sv */
module tb_fpu_top;

    timeunit 1ns;
    timeprecision 100ps;

    `include "fpu_ref.svh"

    localparam int seed = 74921;
    localparam int timeout_cycles = 50;
    localparam int n_rand_mul = 80;
    localparam int n_rand_simple = 80;

    logic clk, rst_n, req_valid, is_single;
    logic req_ready, resp_valid;
    fpu_op_pkg::fpu_op_t op;
    logic [63:0] rs1, rs2, result, int_result;
    logic [4:0] fflags;

    logic [63:0] rng_state;
    int cycle = 0;
    int value_errors = 0;
    int timing_errors = 0;

    // Accepted requests still waiting for their response
    fpu_op_pkg::fpu_op_t pend_op[$];
    logic [63:0] pend_a[$];
    logic [63:0] pend_b[$];
    bit pend_sgl[$];
    int pend_cycle[$];

    // +0 -0 +sub -sub +inf -inf qNaN sNaN 1.0 -2.5
    logic [63:0] special_s[10] = '{
        64'hffff_ffff_0000_0000, 64'hffff_ffff_8000_0000, 64'hffff_ffff_0000_0123,
        64'hffff_ffff_8040_0000, 64'hffff_ffff_7f80_0000, 64'hffff_ffff_ff80_0000,
        64'hffff_ffff_7fc0_0000, 64'hffff_ffff_7fa0_0000, 64'hffff_ffff_3f80_0000,
        64'hffff_ffff_c020_0000
    };
    logic [63:0] special_d[10] = '{
        64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0abc,
        64'h800f_0000_0000_0000, 64'h7ff0_0000_0000_0000, 64'hfff0_0000_0000_0000,
        64'h7ff8_0000_0000_0000, 64'h7ff4_0000_0000_0000, 64'h3ff0_0000_0000_0000,
        64'hc004_0000_0000_0000
    };

    fpu_top uut (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_ready(req_ready),
        .op(op), .rs1(rs1), .rs2(rs2), .is_single(is_single),
        .resp_valid(resp_valid), .result(result), .int_result(int_result), .fflags(fflags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [63:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    // Either fully random or with an exponent near the bias
    function automatic logic [63:0] random_operand(input bit sgl);
        logic [63:0] r;
        r = next_random();
        if (sgl)
            return r[0] ? {32'hffff_ffff, r[63:32]}
                        : {32'hffff_ffff, r[63], 8'(95 + r[37:32]), r[22:0]};
        return r[0] ? r : {r[63], 11'(991 + r[37:32]), r[51:0]};
    endfunction

    task automatic abort_on_timeout(input int waited, input string what);
        if (waited > timeout_cycles) begin
            $display("Timed out after %0d cycles waiting for %s", waited, what);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic issue(input fpu_op_pkg::fpu_op_t o, input logic [63:0] a,
                         input logic [63:0] b, input bit sgl);
        int waited;
        waited = 0;
        op = o;
        rs1 = a;
        rs2 = b;
        is_single = sgl;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge clk);
            #1;
            waited++;
            abort_on_timeout(waited, "req_ready");
        end
        // Accept edge
        @(posedge clk);
        #1;
        pend_op.push_back(o);
        pend_a.push_back(a);
        pend_b.push_back(b);
        pend_sgl.push_back(sgl);
        pend_cycle.push_back(cycle);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pend_op.size() > 0) begin
            @(posedge clk);
            #1;
            waited++;
            abort_on_timeout(waited, "resp_valid");
        end
    endtask

    // ====================
    // Response checking
    // ====================

    always @(negedge clk) begin : check_response
        logic [63:0] a, b, exp_res, exp_int;
        logic [4:0] exp_fl;
        fpu_op_pkg::fpu_op_t o;
        bit sgl;
        int lat;
        if (rst_n) begin
            if (pend_op.size() > 0) begin
                assert (!req_ready) else begin
                    timing_errors++;
                    $display("Fail %0t: req_ready high with a request in flight", $time);
                end
            end
            if (resp_valid) begin
                assert (pend_op.size() > 0) else begin
                    timing_errors++;
                    $display("Response pulse at %0t with no request in flight", $time);
                end
            end
            if (resp_valid && pend_op.size() > 0) begin
                o = pend_op.pop_front();
                a = pend_a.pop_front();
                b = pend_b.pop_front();
                sgl = pend_sgl.pop_front();
                lat = cycle - pend_cycle.pop_front();
                exp_int = '0;
                if (o == fpu_op_pkg::FPU_MUL)
                    exp_res = mul_expected(a, b, sgl, exp_fl);
                else
                    exp_res = simple_expected(o, a, b, sgl, exp_int, exp_fl);
                assert (lat == ((o == fpu_op_pkg::FPU_MUL) ? 4 : 3)) else begin
                    timing_errors++;
                    $display("Fail %0t: %s answered after %0d cycles", $time, o.name(), lat);
                end
                assert (result === exp_res && int_result === exp_int && fflags === exp_fl)
                else begin
                    value_errors++;
                    $display("Fail %0t: %s a=%h b=%h single=%0d got %h/%h/%b expected %h/%h/%b",
                             $time, o.name(), a, b, sgl, result, int_result, fflags,
                             exp_res, exp_int, exp_fl);
                end
            end else if (!resp_valid) begin
                assert (result == 0 && int_result == 0 && fflags == 0) else begin
                    value_errors++;
                    $display("Fail %0t: response outputs nonzero without resp_valid", $time);
                end
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        logic [63:0] a, b, r;
        rng_state = 64'(seed);
        rst_n = 1'b0;
        req_valid = 1'b0;
        op = fpu_op_pkg::FPU_SGNJ;
        rs1 = '0;
        rs2 = '0;
        is_single = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (req_ready && !resp_valid) else begin
            timing_errors++;
            $display("Fail %0t: handshake state wrong after reset", $time);
        end

        // Every special pair through every operation
        for (int f = 0; f < 2; f++)
            for (int i = 0; i < 10; i++)
                for (int j = 0; j < 10; j++)
                    for (int k = 0; k < 10; k++) begin
                        a = f[0] ? special_s[i] : special_d[i];
                        b = f[0] ? special_s[j] : special_d[j];
                        issue(fpu_op_pkg::fpu_op_t'(k), a, b, f[0]);
                    end

        for (int n = 0; n < n_rand_mul; n++) begin
            r = next_random();
            issue(fpu_op_pkg::FPU_MUL, random_operand(r[0]), random_operand(r[0]), r[0]);
        end

        // Equal operands now and then for EQ and LE
        for (int n = 0; n < n_rand_simple; n++) begin
            r = next_random();
            a = random_operand(r[0]);
            b = r[1] ? a : random_operand(r[0]);
            issue(fpu_op_pkg::fpu_op_t'(1 + r[15:8] % 9), a, b, r[0]);
        end

        wait_drain();
        repeat (2) @(posedge clk);
        $display("errors: %0d value, %0d timing", value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/fp_format_pkg.sv */
package fp_format_pkg;

    // ====================
    // IEEE 754 formats
    // ====================

    localparam int s_exp_bits = 8;
    localparam int s_mant_bits = 23;
    localparam int s_bias = 127;

    localparam int d_exp_bits = 11;
    localparam int d_mant_bits = 52;
    localparam int d_bias = 1023;

    // ====================
    // Datapath widths
    // ====================

    // Operand or result register, single values NaN-boxed in the low half
    typedef logic [63:0] fp_word_t;

    // Extended exponent, always in double bias
    typedef logic signed [12:0] fp_exp_t;

    // Significand with hidden one at the top
    typedef logic [52:0] fp_mant_t;

    typedef logic [105:0] fp_prod_t;

endpackage

/* verilog/fp_mul_path.sv */
module fp_mul_path (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mul_load,
    input  logic                     mul_finish,
    input  logic                     is_single,
    input  logic                     a_sign,
    input  fp_format_pkg::fp_exp_t   a_exp,
    input  fp_format_pkg::fp_mant_t  a_mant,
    input  logic                     a_zero,
    input  logic                     a_inf,
    input  logic                     a_nan,
    input  logic                     a_snan,
    input  logic                     b_sign,
    input  fp_format_pkg::fp_exp_t   b_exp,
    input  fp_format_pkg::fp_mant_t  b_mant,
    input  logic                     b_zero,
    input  logic                     b_inf,
    input  logic                     b_nan,
    input  logic                     b_snan,
    output fp_format_pkg::fp_word_t  mul_result,
    output fpu_op_pkg::fflags_t      mul_flags
);

    fp_format_pkg::fp_prod_t  prod_q;
    fp_format_pkg::fp_exp_t   exp_q;
    logic sign_q, nan_q, nv_q, inf_q, zero_q;

    fp_format_pkg::fp_exp_t   exp_n, exp_f, exp_top;
    logic [51:0]              frac;
    logic                     lost;
    fp_format_pkg::fp_word_t  res_d;
    fpu_op_pkg::fflags_t      flags_d;

    // Builds a word from sign, double-width exponent field and fraction
    function automatic fp_format_pkg::fp_word_t pack(input logic single, input logic s,
                                                     input logic [10:0] e,
                                                     input logic [51:0] f);
        if (single)
            return {32'hffff_ffff, s, e[7:0], f[51:29]};
        return {s, e, f};
    endfunction

    // ====================
    // Product stage
    // ====================

    always_ff @(posedge clk) begin
        if (mul_load) begin
            prod_q <= a_mant * b_mant;
            exp_q <= a_exp + b_exp - fp_format_pkg::fp_exp_t'(fp_format_pkg::d_bias);
            sign_q <= a_sign ^ b_sign;
            nan_q <= a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf);
            // inf * 0 is invalid even without a NaN input
            nv_q <= (a_nan || b_nan) ? (a_snan || b_snan)
                                     : ((a_inf && b_zero) || (a_zero && b_inf));
            inf_q <= a_inf || b_inf;
            zero_q <= a_zero || b_zero;
        end
    end

    // ====================
    // Normalize and pack
    // ====================

    always_comb begin
        exp_n = exp_q + fp_format_pkg::fp_exp_t'(prod_q[105]);
        exp_f = is_single
              ? exp_n - fp_format_pkg::fp_exp_t'(fp_format_pkg::d_bias - fp_format_pkg::s_bias)
              : exp_n;
        exp_top = is_single
                ? fp_format_pkg::fp_exp_t'((1 << fp_format_pkg::s_exp_bits) - 1)
                : fp_format_pkg::fp_exp_t'((1 << fp_format_pkg::d_exp_bits) - 1);
        frac = prod_q[105] ? prod_q[104:53] : prod_q[103:52];
        // Single also drops the low 29 fraction bits
        lost = (prod_q[105] ? |prod_q[52:0] : |prod_q[51:0]) | (is_single & (|frac[28:0]));

        flags_d = '0;
        if (nan_q) begin
            res_d = pack(is_single, 1'b0, '1, {1'b1, 51'b0});
            flags_d[fpu_op_pkg::flag_nv] = nv_q;
        end else if (inf_q) begin
            res_d = pack(is_single, sign_q, '1, '0);
        end else if (zero_q) begin
            res_d = pack(is_single, sign_q, '0, '0);
        end else if (exp_f >= exp_top) begin
            res_d = pack(is_single, sign_q, '1, '0);
            flags_d[fpu_op_pkg::flag_of] = 1'b1;
            flags_d[fpu_op_pkg::flag_nx] = 1'b1;
        end else if (exp_f <= 0) begin
            res_d = pack(is_single, sign_q, '0, '0);
            flags_d[fpu_op_pkg::flag_uf] = 1'b1;
            flags_d[fpu_op_pkg::flag_nx] = 1'b1;
        end else begin
            res_d = pack(is_single, sign_q, exp_f[10:0], frac);
            flags_d[fpu_op_pkg::flag_nx] = lost;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_result <= '0;
            mul_flags <= '0;
        end else if (mul_finish) begin
            mul_result <= res_d;
            mul_flags <= flags_d;
        end
    end

endmodule

/* verilog/fp_simple_ops.sv */
module fp_simple_ops (
    input  fpu_op_pkg::fpu_op_t      op,
    input  logic                     is_single,
    input  fp_format_pkg::fp_word_t  rs1,
    input  fp_format_pkg::fp_word_t  rs2,
    input  logic                     a_sign,
    input  fp_format_pkg::fp_exp_t   a_exp,
    input  fp_format_pkg::fp_mant_t  a_mant,
    input  logic                     a_zero,
    input  logic                     a_nan,
    input  logic                     a_snan,
    input  logic                     b_sign,
    input  fp_format_pkg::fp_exp_t   b_exp,
    input  fp_format_pkg::fp_mant_t  b_mant,
    input  logic                     b_zero,
    input  logic                     b_nan,
    input  logic                     b_snan,
    output fp_format_pkg::fp_word_t  simple_result,
    output logic [63:0]              simple_int,
    output fpu_op_pkg::fflags_t      simple_flags
);

    logic inj_sign, raw_frac_zero, both_zero, mag_lt, mag_eq, eq, lt, any_nan;
    logic [3:0] class_idx;
    fp_format_pkg::fp_word_t inj_word, canon_nan;

    function automatic fp_format_pkg::fp_word_t box(input fp_format_pkg::fp_word_t w,
                                                    input logic single);
        return single ? {32'hffff_ffff, w[31:0]} : w;
    endfunction

    // ====================
    // Raw bit operations
    // ====================

    always_comb begin
        case (op)
            fpu_op_pkg::FPU_SGNJ:  inj_sign = b_sign;
            fpu_op_pkg::FPU_SGNJN: inj_sign = !b_sign;
            default:               inj_sign = a_sign ^ b_sign;
        endcase
        inj_word = is_single ? {32'hffff_ffff, inj_sign, rs1[30:0]} : {inj_sign, rs1[62:0]};

        // RISC-V class mask from bit 0 (-inf) up to bit 9 (qNaN)
        raw_frac_zero = is_single ? (rs1[22:0] == '0) : (rs1[51:0] == '0);
        if (a_nan)
            class_idx = a_snan ? 4'd8 : 4'd9;
        else if (a_zero)
            class_idx = raw_frac_zero ? (a_sign ? 4'd3 : 4'd4) : (a_sign ? 4'd2 : 4'd5);
        else if (a_exp == fp_format_pkg::fp_exp_t'(2047) || (is_single && &rs1[30:23]))
            class_idx = a_sign ? 4'd0 : 4'd7;
        else
            class_idx = a_sign ? 4'd1 : 4'd6;
    end

    // ====================
    // Ordering
    // ====================

    assign any_nan = a_nan || b_nan;
    assign both_zero = a_zero && b_zero;
    assign mag_lt = {a_exp, a_mant} < {b_exp, b_mant};
    assign mag_eq = {a_exp, a_mant} == {b_exp, b_mant};
    assign eq = both_zero || (a_sign == b_sign && mag_eq);
    assign lt = !both_zero && ((a_sign != b_sign) ? a_sign : ((a_sign ^ mag_lt) && !eq));
    assign canon_nan = is_single ? {32'hffff_ffff, 32'h7fc0_0000} : 64'h7ff8_0000_0000_0000;

    always_comb begin
        simple_result = '0;
        simple_int = '0;
        simple_flags = '0;
        case (op)
            fpu_op_pkg::FPU_SGNJ, fpu_op_pkg::FPU_SGNJN, fpu_op_pkg::FPU_SGNJX:
                simple_result = inj_word;
            fpu_op_pkg::FPU_CLASS:
                simple_int = 64'd1 << class_idx;
            fpu_op_pkg::FPU_CMP_EQ: begin
                simple_int = {63'b0, eq && !any_nan};
                simple_flags[fpu_op_pkg::flag_nv] = a_snan || b_snan;
            end
            fpu_op_pkg::FPU_CMP_LT: begin
                simple_int = {63'b0, lt && !any_nan};
                simple_flags[fpu_op_pkg::flag_nv] = any_nan;
            end
            fpu_op_pkg::FPU_CMP_LE: begin
                simple_int = {63'b0, (lt || eq) && !any_nan};
                simple_flags[fpu_op_pkg::flag_nv] = any_nan;
            end
            fpu_op_pkg::FPU_MIN, fpu_op_pkg::FPU_MAX: begin
                simple_flags[fpu_op_pkg::flag_nv] = a_snan || b_snan;
                if (a_nan && b_nan)
                    simple_result = canon_nan;
                else if (a_nan)
                    simple_result = box(rs2, is_single);
                else if (b_nan)
                    simple_result = box(rs1, is_single);
                else if (lt ^ (op == fpu_op_pkg::FPU_MAX))
                    simple_result = box(rs1, is_single);
                else
                    simple_result = box(rs2, is_single);
            end
            default: ;
        endcase
    end

endmodule

/* verilog/fp_unpack.sv */
module fp_unpack (
    input  fp_format_pkg::fp_word_t  word,
    input  logic                     is_single,
    output logic                     sign,
    output fp_format_pkg::fp_exp_t   exp,
    output fp_format_pkg::fp_mant_t  mant,
    output logic                     is_zero,
    output logic                     is_inf,
    output logic                     is_nan,
    output logic                     is_snan
);

    localparam int pad = fp_format_pkg::d_mant_bits - fp_format_pkg::s_mant_bits;

    logic [fp_format_pkg::s_exp_bits-1:0]   s_exp_f;
    logic [fp_format_pkg::s_mant_bits-1:0]  s_frac;
    logic [fp_format_pkg::d_exp_bits-1:0]   d_exp_f;
    logic [fp_format_pkg::d_mant_bits-1:0]  d_frac;
    logic exp_zero, exp_max, frac_zero, quiet;

    assign s_exp_f = word[30:23];
    assign s_frac = word[22:0];
    assign d_exp_f = word[62:52];
    assign d_frac = word[51:0];

    always_comb begin
        if (is_single) begin
            sign = word[31];
            exp_zero = (s_exp_f == '0);
            exp_max = &s_exp_f;
            frac_zero = (s_frac == '0);
            quiet = s_frac[fp_format_pkg::s_mant_bits-1];
            // Rebias to double
            exp = fp_format_pkg::fp_exp_t'(s_exp_f)
                + fp_format_pkg::fp_exp_t'(fp_format_pkg::d_bias - fp_format_pkg::s_bias);
            mant = {1'b1, s_frac, {pad{1'b0}}};
        end else begin
            sign = word[63];
            exp_zero = (d_exp_f == '0);
            exp_max = &d_exp_f;
            frac_zero = (d_frac == '0);
            quiet = d_frac[fp_format_pkg::d_mant_bits-1];
            exp = fp_format_pkg::fp_exp_t'(d_exp_f);
            mant = {1'b1, d_frac};
        end

        // Denormals collapse to zero of the same sign
        if (exp_zero) begin
            exp = '0;
            mant = '0;
        end

        is_zero = exp_zero;
        is_inf = exp_max && frac_zero;
        is_nan = exp_max && !frac_zero;
        is_snan = exp_max && !frac_zero && !quiet;
    end

endmodule

/* verilog/fpu_ctrl.sv */
module fpu_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  fpu_op_pkg::fpu_op_t      op,
    input  fp_format_pkg::fp_word_t  rs1,
    input  fp_format_pkg::fp_word_t  rs2,
    input  logic                     is_single,
    input  fp_format_pkg::fp_word_t  simple_result,
    input  logic [63:0]              simple_int,
    input  fpu_op_pkg::fflags_t      simple_flags,
    input  fp_format_pkg::fp_word_t  mul_result,
    input  fpu_op_pkg::fflags_t      mul_flags,
    output logic                     req_ready,
    output logic                     resp_valid,
    output fp_format_pkg::fp_word_t  rs1_q,
    output fp_format_pkg::fp_word_t  rs2_q,
    output fpu_op_pkg::fpu_op_t      op_q,
    output logic                     is_single_q,
    output logic                     mul_load,
    output logic                     mul_finish,
    output fp_format_pkg::fp_word_t  result,
    output logic [63:0]              int_result,
    output fpu_op_pkg::fflags_t      fflags
);

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        UNPACK,
        SIMPLE,
        MUL,
        NORM,
        DONE
    } ctrl_state_t;

    ctrl_state_t state, next_state;

    fp_format_pkg::fp_word_t  simple_result_q;
    logic [63:0]              simple_int_q;
    fpu_op_pkg::fflags_t      simple_flags_q;

    // ====================
    // State machine
    // ====================

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (req_valid) next_state = CAPTURE;
            CAPTURE: next_state = UNPACK;
            UNPACK:  next_state = (op_q == fpu_op_pkg::FPU_MUL) ? MUL : SIMPLE;
            SIMPLE:  next_state = DONE;
            MUL:     next_state = NORM;
            NORM:    next_state = DONE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign req_ready = (state == IDLE);
    assign resp_valid = (state == DONE);
    assign mul_load = (state == UNPACK) && (op_q == fpu_op_pkg::FPU_MUL);
    assign mul_finish = (state == NORM);

    // Request capture and simple result hold
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op_q <= op;
            rs1_q <= rs1;
            rs2_q <= rs2;
            is_single_q <= is_single;
        end
        if (state == SIMPLE) begin
            simple_result_q <= simple_result;
            simple_int_q <= simple_int;
            simple_flags_q <= simple_flags;
        end
    end

    // Response is zero outside the DONE cycle
    always_comb begin
        result = '0;
        int_result = '0;
        fflags = '0;
        if (state == DONE) begin
            if (op_q == fpu_op_pkg::FPU_MUL) begin
                result = mul_result;
                fflags = mul_flags;
            end else begin
                result = simple_result_q;
                int_result = simple_int_q;
                fflags = simple_flags_q;
            end
        end
    end

endmodule

/* verilog/fpu_op_pkg.sv */
package fpu_op_pkg;

    typedef enum logic [3:0] {
        FPU_MUL,
        FPU_SGNJ,
        FPU_SGNJN,
        FPU_SGNJX,
        FPU_MIN,
        FPU_MAX,
        FPU_CMP_EQ,
        FPU_CMP_LT,
        FPU_CMP_LE,
        FPU_CLASS
    } fpu_op_t;

    // Accrued exception flags, NV DZ OF UF NX from msb down
    typedef logic [4:0] fflags_t;

    localparam int flag_nv = 4;
    localparam int flag_dz = 3;
    localparam int flag_of = 2;
    localparam int flag_uf = 1;
    localparam int flag_nx = 0;

endpackage

/* verilog/fpu_top.sv */
module fpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  fpu_op_pkg::fpu_op_t      op,
    input  fp_format_pkg::fp_word_t  rs1,
    input  fp_format_pkg::fp_word_t  rs2,
    input  logic                     is_single,
    output logic                     resp_valid,
    output fp_format_pkg::fp_word_t  result,
    output logic [63:0]              int_result,
    output fpu_op_pkg::fflags_t      fflags
);

    fp_format_pkg::fp_word_t  rs1_q, rs2_q;
    fpu_op_pkg::fpu_op_t      op_q;
    logic                     is_single_q;

    // Unpacked operands
    logic                     a_sign, a_zero, a_inf, a_nan, a_snan;
    fp_format_pkg::fp_exp_t   a_exp;
    fp_format_pkg::fp_mant_t  a_mant;
    logic                     b_sign, b_zero, b_inf, b_nan, b_snan;
    fp_format_pkg::fp_exp_t   b_exp;
    fp_format_pkg::fp_mant_t  b_mant;

    logic                     mul_load, mul_finish;
    fp_format_pkg::fp_word_t  mul_result;
    fpu_op_pkg::fflags_t      mul_flags;
    fp_format_pkg::fp_word_t  simple_result;
    logic [63:0]              simple_int;
    fpu_op_pkg::fflags_t      simple_flags;

    fpu_ctrl ctrl (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .op(op),
        .rs1(rs1), .rs2(rs2), .is_single(is_single),
        .simple_result(simple_result), .simple_int(simple_int),
        .simple_flags(simple_flags), .mul_result(mul_result), .mul_flags(mul_flags),
        .req_ready(req_ready), .resp_valid(resp_valid), .rs1_q(rs1_q), .rs2_q(rs2_q),
        .op_q(op_q), .is_single_q(is_single_q), .mul_load(mul_load),
        .mul_finish(mul_finish), .result(result), .int_result(int_result), .fflags(fflags)
    );

    fp_unpack unpack_a (
        .word(rs1_q), .is_single(is_single_q), .sign(a_sign), .exp(a_exp), .mant(a_mant),
        .is_zero(a_zero), .is_inf(a_inf), .is_nan(a_nan), .is_snan(a_snan)
    );

    fp_unpack unpack_b (
        .word(rs2_q), .is_single(is_single_q), .sign(b_sign), .exp(b_exp), .mant(b_mant),
        .is_zero(b_zero), .is_inf(b_inf), .is_nan(b_nan), .is_snan(b_snan)
    );

    fp_mul_path mul_path (
        .clk(clk), .rst_n(rst_n), .mul_load(mul_load), .mul_finish(mul_finish),
        .is_single(is_single_q),
        .a_sign(a_sign), .a_exp(a_exp), .a_mant(a_mant), .a_zero(a_zero),
        .a_inf(a_inf), .a_nan(a_nan), .a_snan(a_snan),
        .b_sign(b_sign), .b_exp(b_exp), .b_mant(b_mant), .b_zero(b_zero),
        .b_inf(b_inf), .b_nan(b_nan), .b_snan(b_snan),
        .mul_result(mul_result), .mul_flags(mul_flags)
    );

    fp_simple_ops simple_ops (
        .op(op_q), .is_single(is_single_q), .rs1(rs1_q), .rs2(rs2_q),
        .a_sign(a_sign), .a_exp(a_exp), .a_mant(a_mant), .a_zero(a_zero),
        .a_nan(a_nan), .a_snan(a_snan),
        .b_sign(b_sign), .b_exp(b_exp), .b_mant(b_mant), .b_zero(b_zero),
        .b_nan(b_nan), .b_snan(b_snan),
        .simple_result(simple_result), .simple_int(simple_int), .simple_flags(simple_flags)
    );

endmodule
